//--- build.f
source/radio_pkg.sv
source/db_control.sv
source/fe_control.sv
source/tag_rx_detect.sv
source/radio_core.sv
tests/radio_checker.sv
tests/tb_radio_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the radio core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_radio_core -f build.f \
   -o sim_radio_core > sim.log 2>&1 \
   && ./obj_dir/sim_radio_core >> sim.log 2>&1 \
   || { cat sim.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

//--- tests/tb_radio_core.sv
/* radio core testbench
   table of writes, readbacks and samples applied on falling edges */
`timescale 1ns/1ps
`default_nettype none

module tb_radio_core;

   localparam int K_IDLE = 0, K_WRITE = 1, K_READ = 2, K_RX = 3;
   localparam int K_TX = 4, K_SAMPLE = 5, K_FPIN = 6;
   // check codes, decoded by the checker
   localparam int C_NONE = 0, C_DB0_OUT = 1, C_DB0_DDR = 2, C_LED0 = 3, C_MISC0 = 4;
   localparam int C_DB1_OUT = 5, C_DB1_DDR = 6, C_LED1 = 7, C_MISC1 = 8, C_RB = 9;
   localparam int C_RX0 = 10, C_TX0 = 14, C_TX1 = 15, C_FP = 16, C_FP_DDR = 17;
   localparam logic [31:0] MISC0_PIN = 32'h0000_1111, MISC1_PIN = 32'h0000_3333;
   localparam logic [31:0] DB0_PIN = 32'hDB00_0001, DB1_PIN = 32'hDB11_0002;
   localparam logic [31:0] FP_PIN = 32'h0000_0F00;   // tag enable bit clear

   typedef struct {
      logic [159:0] name;
      int           kind;
      logic         db;
      logic [7:0]   addr;
      logic [31:0]  data;   // mode for random sample rows
      int           chk;
      logic [63:0]  exp;
   } row_t;

   logic radio_clk = 1'b0;
   logic i_rst_n;
   radio_pkg::settings_bus_t i_set;
   radio_pkg::readback_req_t i_rb;
   logic [31:0] i_rx0, i_rx1, i_tx0, i_tx1, i_db0_gpio_in, i_db1_gpio_in, i_fp_gpio_in;
   logic [31:0] i_radio0_misc_in, i_radio1_misc_in;
   logic [3:0][31:0] o_rx_chan;
   logic [31:0] o_tx0, o_tx1, o_db0_gpio_out, o_db0_gpio_ddr, o_db1_gpio_out, o_db1_gpio_ddr;
   logic [31:0] o_fp_gpio_out, o_fp_gpio_ddr, o_radio0_misc_out, o_radio1_misc_out;
   logic [2:0] o_radio_led0, o_radio_led1;
   logic o_rb_valid;
   logic [63:0] o_rb_data;

   row_t rows[$];
   int seed = 61;
   int errors, checks, n_checks;
   logic timed_out, done, cur_active, cur_read;
   logic [159:0] cur_name;
   logic [4:0] cur_chk;
   logic [63:0] cur_exp;

   always #4 radio_clk = ~radio_clk;   // 8 ns

   radio_core #(.NUM_DBOARDS(2), .TAG_HOLD(4)) radio_core_i (.*);

   radio_checker radio_checker_i (
      .radio_clk (radio_clk), .i_rst_n (i_rst_n), .i_active (cur_active),
      .i_is_read (cur_read), .i_done (done), .i_name (cur_name),
      .i_chk (cur_chk), .i_exp (cur_exp), .i_rx_chan (o_rx_chan),
      .i_tx0 (o_tx0), .i_tx1 (o_tx1),
      .i_db0_gpio_out (o_db0_gpio_out), .i_db0_gpio_ddr (o_db0_gpio_ddr),
      .i_db1_gpio_out (o_db1_gpio_out), .i_db1_gpio_ddr (o_db1_gpio_ddr),
      .i_fp_gpio_out (o_fp_gpio_out), .i_fp_gpio_ddr (o_fp_gpio_ddr),
      .i_led0 (o_radio_led0), .i_led1 (o_radio_led1),
      .i_misc0_out (o_radio0_misc_out), .i_misc1_out (o_radio1_misc_out),
      .i_rb_valid (o_rb_valid), .i_rb_data (o_rb_data),
      .o_errors (errors), .o_checks (checks)
   );

   // front-end rule: pass, swap I and Q, negate Q, mute
   function automatic logic [31:0] condition_sample(input logic [1:0] mode,
                                                    input logic [31:0] s);
      logic [15:0] i_v;
      logic [15:0] q_v;
      i_v = s[31:16];
      q_v = s[15:0];
      case (mode)
         2'd1:    condition_sample = {q_v, i_v};
         2'd2:    condition_sample = {i_v, 16'(16'd0 - q_v)};
         2'd3:    condition_sample = '0;
         default: condition_sample = s;
      endcase
   endfunction

   task automatic add_row(input logic [159:0] name, input int kind, input int db,
                          input int addr, input logic [31:0] data, input int chk,
                          input logic [63:0] exp);
      row_t r;
      r = '{name, kind, db[0], addr[7:0], data, chk, exp};
      rows.push_back(r);
   endtask

   task automatic build_table();
      // --------------------
      // board registers, then the other board left alone
      add_row("db0_gpio_out", K_WRITE, 0, 160, 32'hA5A5_0001, C_DB0_OUT, 64'hA5A5_0001);
      add_row("db0_gpio_ddr", K_WRITE, 0, 161, 32'h0000_FFFF, C_DB0_DDR, 64'h0000_FFFF);
      add_row("db0_leds", K_WRITE, 0, 162, 32'h7, C_LED0, 64'h7);
      add_row("db0_misc_out", K_WRITE, 0, 163, 32'hCAFE_0000, C_MISC0, 64'hCAFE_0000);
      add_row("db1_out_idle", K_IDLE, 0, 0, 0, C_DB1_OUT, 64'h0);
      add_row("db1_gpio_out", K_WRITE, 1, 160, 32'h1234_8765, C_DB1_OUT, 64'h1234_8765);
      add_row("db1_gpio_ddr", K_WRITE, 1, 161, 32'hFF00_0000, C_DB1_DDR, 64'hFF00_0000);
      add_row("db1_leds", K_WRITE, 1, 162, 32'h5, C_LED1, 64'h5);
      add_row("db1_misc_out", K_WRITE, 1, 163, 32'h0BAD_F00D, C_MISC1, 64'h0BAD_F00D);
      add_row("db0_leds_kept", K_IDLE, 0, 0, 0, C_LED0, 64'h7);
      add_row("db0_misc_kept", K_IDLE, 0, 0, 0, C_MISC0, 64'hCAFE_0000);
      // readback, back to back
      add_row("db0_rb_misc_in", K_READ, 0, 16, 0, C_RB, 64'(MISC0_PIN));
      add_row("db0_rb_gpio_in", K_READ, 0, 17, 0, C_RB, 64'(DB0_PIN));
      add_row("db0_rb_fp_in", K_READ, 0, 18, 0, C_RB, 64'(FP_PIN));
      add_row("db0_rb_echo", K_READ, 0, 19, 0, C_RB, 64'hCAFE_0000_A5A5_0001);
      add_row("db1_rb_misc_in", K_READ, 1, 16, 0, C_RB, 64'(MISC1_PIN));
      add_row("db1_rb_gpio_in", K_READ, 1, 17, 0, C_RB, 64'(DB1_PIN));
      add_row("db1_rb_fp_in", K_READ, 1, 18, 0, C_RB, 64'(FP_PIN));
      add_row("db1_rb_echo", K_READ, 1, 19, 0, C_RB, 64'h0BAD_F00D_1234_8765);
      add_row("db1_rb_unknown", K_READ, 1, 40, 0, C_RB, 64'h0);
      add_row("rb_idle", K_IDLE, 0, 0, 0, C_NONE, 64'h0);
      // --------------------
      // front-end modes on every channel
      for (int ch = 0; ch < 4; ch++) begin
         for (int m = 0; m < 4; m++) begin
            add_row("rx_mode_set", K_WRITE, ch / 2, 224 + 16 * (ch % 2), m, C_NONE, 0);
            add_row("rx_mode_sample", K_RX, 0, 0, m, C_RX0 + ch, 0);
         end
         add_row("rx_mode_pass", K_WRITE, ch / 2, 224 + 16 * (ch % 2), 0, C_NONE, 0);
      end
      for (int b = 0; b < 2; b++) begin
         for (int m = 0; m < 4; m++) begin
            add_row("tx_mode_set", K_WRITE, b, 208, m, C_NONE, 0);
            add_row("tx_mode_sample", K_TX, 0, 0, m, C_TX0 + b, 0);
         end
      end
      // --------------------
      // tag detector on board 1 channel 0, threshold 0x1000
      add_row("tag_quiet", K_SAMPLE, 0, 0, 32'h0000_0000, C_NONE, 0);   // weak sample first
      add_row("tag_thresh", K_WRITE, 1, 176, 32'h1000, C_NONE, 0);
      add_row("tag_enable", K_FPIN, 0, 0, FP_PIN | 32'h2, C_NONE, 0);
      add_row("tag_run0", K_SAMPLE, 0, 0, 32'h2000_0001, C_RX0 + 2, 64'h2000_0001);
      add_row("tag_run1_neg", K_SAMPLE, 0, 0, 32'hE000_0002, C_RX0 + 2, 64'hE000_0002);
      add_row("tag_run2_equal", K_SAMPLE, 0, 0, 32'h1000_0003, C_RX0 + 2, 64'h1000_0003);
      add_row("tag_run3", K_SAMPLE, 0, 0, 32'h3000_0004, C_RX0 + 2, 64'h3000_0004);
      add_row("tag_overlay_ch0", K_SAMPLE, 0, 0, 32'h2000_0005, C_RX0, 64'h3000_0004);
      add_row("tag_overlay_ch3", K_SAMPLE, 0, 0, 32'h2000_0006, C_RX0 + 3, 64'h2000_0005);
      add_row("tag_led_on", K_SAMPLE, 0, 0, 32'h2000_0007, C_FP, 64'h1);
      add_row("tag_overlay_ch1", K_SAMPLE, 0, 0, 32'h0100_0008, C_RX0 + 1, 64'h2000_0007);
      add_row("tag_low_ends", K_SAMPLE, 0, 0, 32'h2000_0009, C_RX0 + 1, 64'h2000_0009);
      add_row("tag_led_off", K_IDLE, 0, 0, 0, C_FP, 64'h0);
      add_row("tag_rearm", K_IDLE, 0, 0, 0, C_NONE, 0);
      add_row("tag_rearm", K_IDLE, 0, 0, 0, C_NONE, 0);
      add_row("tag_rearm", K_IDLE, 0, 0, 0, C_NONE, 0);
      add_row("tag_rearm_led", K_IDLE, 0, 0, 0, C_FP, 64'h1);
      add_row("tag_disable", K_FPIN, 0, 0, FP_PIN, C_NONE, 0);
      add_row("tag_enable_off", K_IDLE, 0, 0, 0, C_FP, 64'h0);
      add_row("fp_ddr", K_IDLE, 0, 0, 0, C_FP_DDR, 64'h1);
   endtask

   task automatic drive_row(input row_t r);
      logic [31:0] s0;
      logic [31:0] s1;
      logic [63:0] exp;
      exp   = r.exp;
      i_set = '0;
      i_rb  = '0;
      case (r.kind)
         K_WRITE: i_set = '{stb: 1'b1, db_sel: r.db, addr: r.addr, data: r.data};
         K_READ:  i_rb  = '{stb: 1'b1, db_sel: r.db, addr: r.addr};
         K_RX: begin
            s0    = $random(seed);
            s1    = $random(seed);
            i_rx0 = s0;
            i_rx1 = s1;
            exp   = 64'(condition_sample(r.data[1:0], (r.chk < C_RX0 + 2) ? s0 : s1));
         end
         K_TX: begin
            s0    = $random(seed);
            s1    = $random(seed);
            i_tx0 = s0;
            i_tx1 = s1;
            exp   = 64'(condition_sample(r.data[1:0], (r.chk == C_TX0) ? s0 : s1));
         end
         K_SAMPLE: begin
            i_rx0 = r.data;   // both radios carry the same sample
            i_rx1 = r.data;
         end
         K_FPIN:  i_fp_gpio_in = r.data;
         default: ;
      endcase
      cur_name   = r.name;
      cur_chk    = 5'(r.chk);
      cur_exp    = exp;
      cur_read   = (r.kind == K_READ);
      cur_active = 1'b1;
   endtask

   task automatic wait_cycles(input int n);
      for (int k = 0; k < n; k++) begin
         @(negedge radio_clk);
      end
   endtask

   initial begin
      i_rst_n = 1'b0;
      i_set = '0;
      i_rb = '0;
      i_rx0 = '0;
      i_rx1 = '0;
      i_tx0 = '0;
      i_tx1 = '0;
      i_db0_gpio_in = DB0_PIN;
      i_db1_gpio_in = DB1_PIN;
      i_fp_gpio_in = FP_PIN;
      i_radio0_misc_in = MISC0_PIN;
      i_radio1_misc_in = MISC1_PIN;
      cur_active = 1'b0;
      cur_read = 1'b0;
      cur_name = '0;
      cur_chk = '0;
      cur_exp = '0;
      done = 1'b0;
      timed_out = 1'b0;
      n_checks = 0;
      build_table();
      wait_cycles(10);
      i_rst_n = 1'b1;
      wait_cycles(2);
      foreach (rows[k]) begin
         drive_row(rows[k]);
         if (rows[k].chk != C_NONE) n_checks++;
         @(negedge radio_clk);
      end
      cur_active = 1'b0;
      i_set = '0;
      i_rb = '0;
      // the checker lags the table by one cycle
      for (int t = 0; t < 20 && checks < n_checks; t++) begin
         @(posedge radio_clk);
      end
      if (checks < n_checks) begin
         timed_out = 1'b1;
         $display("timeout: checker finished %0d of %0d checks", checks, n_checks);
      end
      done = 1'b1;
      @(negedge radio_clk);
      if (errors == 0 && !timed_out) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/radio_checker.sv
/* radio core checker
   latches the expected value per row and compares DUT outputs one cycle later */
`timescale 1ns/1ps
`default_nettype none

module radio_checker (
   input  wire logic                radio_clk,
   input  wire logic                i_rst_n,
   input  wire logic                i_active,
   input  wire logic                i_is_read,
   input  wire logic                i_done,
   input  wire logic [159:0]        i_name,
   input  wire logic [4:0]          i_chk,
   input  wire logic [63:0]         i_exp,
   input  wire logic [3:0][31:0]    i_rx_chan,
   input  wire logic [31:0]         i_tx0,
   input  wire logic [31:0]         i_tx1,
   input  wire logic [31:0]         i_db0_gpio_out,
   input  wire logic [31:0]         i_db0_gpio_ddr,
   input  wire logic [31:0]         i_db1_gpio_out,
   input  wire logic [31:0]         i_db1_gpio_ddr,
   input  wire logic [31:0]         i_fp_gpio_out,
   input  wire logic [31:0]         i_fp_gpio_ddr,
   input  wire logic [2:0]          i_led0,
   input  wire logic [2:0]          i_led1,
   input  wire logic [31:0]         i_misc0_out,
   input  wire logic [31:0]         i_misc1_out,
   input  wire logic                i_rb_valid,
   input  wire logic [63:0]         i_rb_data,
   output int                       o_errors,
   output int                       o_checks
);

   logic         rst_q = 1'b0;
   logic         act_q = 1'b0;
   logic         rd_q = 1'b0;
   logic         reset_checked = 1'b0;
   logic [159:0] name_q;
   logic [4:0]   chk_q;
   logic [63:0]  exp_q;

   initial begin
      o_errors = 0;
      o_checks = 0;
   end

   // output picked by the row's check code, same order as in the testbench
   function automatic logic [63:0] observed(input logic [4:0] sel);
      case (sel)
         5'd1:    observed = 64'(i_db0_gpio_out);
         5'd2:    observed = 64'(i_db0_gpio_ddr);
         5'd3:    observed = 64'(i_led0);
         5'd4:    observed = 64'(i_misc0_out);
         5'd5:    observed = 64'(i_db1_gpio_out);
         5'd6:    observed = 64'(i_db1_gpio_ddr);
         5'd7:    observed = 64'(i_led1);
         5'd8:    observed = 64'(i_misc1_out);
         5'd9:    observed = i_rb_data;
         5'd10, 5'd11, 5'd12, 5'd13:
                  observed = 64'(i_rx_chan[sel - 5'd10]);
         5'd14:   observed = 64'(i_tx0);
         5'd15:   observed = 64'(i_tx1);
         5'd16:   observed = 64'(i_fp_gpio_out);
         5'd17:   observed = 64'(i_fp_gpio_ddr);
         default: observed = '0;
      endcase
   endfunction

   task automatic compare(input logic [159:0] name, input logic [63:0] exp,
                          input logic [63:0] act);
      if (act !== exp) begin
         o_errors++;
         $display("[ERROR] %0s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // --------------------
   // stimulus seen by the DUT at this edge
   always @(posedge radio_clk) begin
      rst_q  <= i_rst_n;
      act_q  <= i_active && i_rst_n;
      rd_q   <= i_active && i_is_read && i_rst_n;
      name_q <= i_name;
      chk_q  <= i_chk;
      exp_q  <= i_exp;
   end

   // outputs are settled at the falling edge
   always @(negedge radio_clk) begin
      if (rst_q && !reset_checked) begin
         reset_checked = 1'b1;
         compare("reset_db0_gpio_out", '0, 64'(i_db0_gpio_out));
         compare("reset_db0_gpio_ddr", '0, 64'(i_db0_gpio_ddr));
         compare("reset_db1_gpio_out", '0, 64'(i_db1_gpio_out));
         compare("reset_db1_gpio_ddr", '0, 64'(i_db1_gpio_ddr));
         compare("reset_leds", '0, 64'({i_led1, i_led0}));
         compare("reset_misc_out", '0, {i_misc1_out, i_misc0_out});
         compare("reset_fp_gpio_out", '0, 64'(i_fp_gpio_out));
      end
      if (rst_q) begin
         compare("rb_valid", 64'(rd_q), 64'(i_rb_valid));   // exactly one cycle per request
      end
      if (act_q && chk_q != 5'd0) begin
         o_checks++;
         compare(name_q, exp_q, observed(chk_q));
      end
   end

   always @(posedge i_done) begin
      $display("checks run: %0d, errors: %0d", o_checks, o_errors);
   end

endmodule

`default_nettype wire

//--- source/radio_core.sv
/* radio core top level
   routes settings and readback per board, maps radios to channels, tag overlay */
`timescale 1ns/1ps
`default_nettype none

module radio_core #(
   parameter int NUM_DBOARDS = 2,
   parameter int TAG_HOLD    = 4
) (
   input  wire logic                                       radio_clk,
   input  wire logic                                       i_rst_n,
   input  wire radio_pkg::settings_bus_t                   i_set,
   input  wire radio_pkg::readback_req_t                   i_rb,
   input  wire logic [radio_pkg::SAMPLE_W-1:0]             i_rx0,
   input  wire logic [radio_pkg::SAMPLE_W-1:0]             i_rx1,
   input  wire logic [radio_pkg::SAMPLE_W-1:0]             i_tx0,
   input  wire logic [radio_pkg::SAMPLE_W-1:0]             i_tx1,
   input  wire logic [radio_pkg::GPIO_W-1:0]               i_db0_gpio_in,
   input  wire logic [radio_pkg::GPIO_W-1:0]               i_db1_gpio_in,
   input  wire logic [radio_pkg::GPIO_W-1:0]               i_fp_gpio_in,
   input  wire logic [radio_pkg::MISC_W-1:0]               i_radio0_misc_in,
   input  wire logic [radio_pkg::MISC_W-1:0]               i_radio1_misc_in,
   output logic [2*NUM_DBOARDS-1:0][radio_pkg::SAMPLE_W-1:0] o_rx_chan,
   output logic [radio_pkg::SAMPLE_W-1:0]                  o_tx0,
   output logic [radio_pkg::SAMPLE_W-1:0]                  o_tx1,
   output logic [radio_pkg::GPIO_W-1:0]                    o_db0_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0]                    o_db0_gpio_ddr,
   output logic [radio_pkg::GPIO_W-1:0]                    o_db1_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0]                    o_db1_gpio_ddr,
   output logic [radio_pkg::GPIO_W-1:0]                    o_fp_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0]                    o_fp_gpio_ddr,
   output logic [radio_pkg::LED_W-1:0]                     o_radio_led0,
   output logic [radio_pkg::LED_W-1:0]                     o_radio_led1,
   output logic [radio_pkg::MISC_W-1:0]                    o_radio0_misc_out,
   output logic [radio_pkg::MISC_W-1:0]                    o_radio1_misc_out,
   output logic                                            o_rb_valid,
   output logic [radio_pkg::RB_DATA_W-1:0]                 o_rb_data
);

   // per-board buses and pins
   radio_pkg::settings_bus_t             set_db      [NUM_DBOARDS];
   radio_pkg::readback_req_t             rb_db       [NUM_DBOARDS];
   logic                                 rb_valid    [NUM_DBOARDS];
   logic [radio_pkg::RB_DATA_W-1:0]      rb_data     [NUM_DBOARDS];
   logic [radio_pkg::SAMPLE_W-1:0]       rx_in       [NUM_DBOARDS];
   logic [radio_pkg::SAMPLE_W-1:0]       tx_in       [NUM_DBOARDS];
   logic [radio_pkg::SAMPLE_W-1:0]       fe_tx       [NUM_DBOARDS];
   logic [1:0][radio_pkg::SAMPLE_W-1:0]  fe_rx       [NUM_DBOARDS];
   logic [radio_pkg::GPIO_W-1:0]         db_gpio_in  [NUM_DBOARDS];
   logic [radio_pkg::GPIO_W-1:0]         db_gpio_out [NUM_DBOARDS];
   logic [radio_pkg::GPIO_W-1:0]         db_gpio_ddr [NUM_DBOARDS];
   logic [radio_pkg::LED_W-1:0]          leds        [NUM_DBOARDS];
   logic [radio_pkg::MISC_W-1:0]         misc_in     [NUM_DBOARDS];
   logic [radio_pkg::MISC_W-1:0]         misc_out    [NUM_DBOARDS];

   // tag detector
   logic                                 tag_valid;
   logic [radio_pkg::SAMPLE_W-1:0]       tag_bb;
   logic [radio_pkg::FP_GPIO_W-1:0]      tag_gpio_out;
   logic [radio_pkg::FP_GPIO_W-1:0]      tag_gpio_ddr;

   // --------------------
   // pin to board mapping
   assign rx_in[0]      = i_rx0;   // each radio feeds both its channels
   assign rx_in[1]      = i_rx1;
   assign tx_in[0]      = i_tx0;
   assign tx_in[1]      = i_tx1;
   assign db_gpio_in[0] = i_db0_gpio_in;
   assign db_gpio_in[1] = i_db1_gpio_in;
   assign misc_in[0]    = i_radio0_misc_in;
   assign misc_in[1]    = i_radio1_misc_in;

   assign o_tx0             = fe_tx[0];   // transmit on even channels only
   assign o_tx1             = fe_tx[1];
   assign o_db0_gpio_out    = db_gpio_out[0];
   assign o_db0_gpio_ddr    = db_gpio_ddr[0];
   assign o_db1_gpio_out    = db_gpio_out[1];
   assign o_db1_gpio_ddr    = db_gpio_ddr[1];
   assign o_radio_led0      = leds[0];
   assign o_radio_led1      = leds[1];
   assign o_radio0_misc_out = misc_out[0];
   assign o_radio1_misc_out = misc_out[1];

   // --------------------
   // per-board control and front end
   for (genvar d = 0; d < NUM_DBOARDS; d++) begin : g_db
      always_comb begin
         set_db[d]     = i_set;
         set_db[d].stb = i_set.stb && (int'(i_set.db_sel) == d);
         rb_db[d]      = i_rb;
         rb_db[d].stb  = i_rb.stb && (int'(i_rb.db_sel) == d);
      end

      db_control db_control_i (
         .radio_clk     (radio_clk),
         .i_rst_n       (i_rst_n),
         .i_set         (set_db[d]),
         .i_rb          (rb_db[d]),
         .i_db_gpio_in  (db_gpio_in[d]),
         .i_fp_gpio_in  (i_fp_gpio_in),
         .i_misc_in     (misc_in[d]),
         .o_db_gpio_out (db_gpio_out[d]),
         .o_db_gpio_ddr (db_gpio_ddr[d]),
         .o_leds        (leds[d]),
         .o_misc_out    (misc_out[d]),
         .o_rb_valid    (rb_valid[d]),
         .o_rb_data     (rb_data[d])
      );

      fe_control fe_control_i (
         .radio_clk (radio_clk),
         .i_rst_n   (i_rst_n),
         .i_set     (set_db[d]),
         .i_rx      (rx_in[d]),
         .i_tx      (tx_in[d]),
         .o_rx      (fe_rx[d]),
         .o_tx      (fe_tx[d])
      );

      // detected tag baseband replaces every receive channel
      for (genvar c = 0; c < 2; c++) begin : g_chan
         assign o_rx_chan[2*d+c] = tag_valid ? tag_bb : fe_rx[d][c];
      end
   end

   // only one board answers per cycle
   always_comb begin
      o_rb_valid = 1'b0;
      o_rb_data  = '0;
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         if (rb_valid[d]) begin
            o_rb_valid = 1'b1;
            o_rb_data  = rb_data[d];
         end
      end
   end

   // --------------------
   // tag detector on board 1, channel 0
   tag_rx_detect #(
      .TAG_HOLD (TAG_HOLD)
   ) tag_rx_detect_i (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_set         (set_db[1]),
      .i_sample      (fe_rx[1][0]),
      .i_fp_gpio_in  (i_fp_gpio_in[radio_pkg::FP_GPIO_W-1:0]),
      .o_rx_valid    (tag_valid),
      .o_baseband    (tag_bb),
      .o_fp_gpio_out (tag_gpio_out),
      .o_fp_gpio_ddr (tag_gpio_ddr)
   );

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         o_fp_gpio_out <= radio_pkg::GPIO_W'(tag_gpio_out);   // upper pins stay 0
         o_fp_gpio_ddr <= radio_pkg::GPIO_W'(tag_gpio_ddr);
      end
   end

endmodule

`default_nettype wire

//--- source/tag_rx_detect.sv
/* tag-chip receive detector
   holds a run of strong I samples, then overlays baseband and lights a pin */
`timescale 1ns/1ps
`default_nettype none

module tag_rx_detect #(
   parameter int TAG_HOLD = 4
) (
   input  wire logic                              radio_clk,
   input  wire logic                              i_rst_n,
   input  wire radio_pkg::settings_bus_t          i_set,
   input  wire logic [radio_pkg::SAMPLE_W-1:0]    i_sample,
   input  wire logic [radio_pkg::FP_GPIO_W-1:0]   i_fp_gpio_in,
   output logic                                   o_rx_valid,
   output logic [radio_pkg::SAMPLE_W-1:0]         o_baseband,
   output logic [radio_pkg::FP_GPIO_W-1:0]        o_fp_gpio_out,
   output logic [radio_pkg::FP_GPIO_W-1:0]        o_fp_gpio_ddr
);

   localparam int CNT_W = $clog2(TAG_HOLD + 1);

   logic [radio_pkg::IQ_W-1:0] thresh;
   logic [radio_pkg::IQ_W-1:0] i_part;
   logic [radio_pkg::IQ_W-1:0] i_mag;
   logic                       tag_en;
   logic                       hit;
   logic [CNT_W-1:0]           hold_cnt;
   logic [CNT_W-1:0]           cnt_next;

   // --------------------
   // threshold register
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         thresh <= '0;
      end else if (i_set.stb && i_set.addr == radio_pkg::SR_TAG_THRESH) begin
         thresh <= i_set.data[radio_pkg::IQ_W-1:0];
      end
   end

   // --------------------
   // magnitude compare
   assign i_part = i_sample[radio_pkg::SAMPLE_W-1 -: radio_pkg::IQ_W];
   assign i_mag  = i_part[radio_pkg::IQ_W-1] ? (~i_part + 1'b1) : i_part;   // -32768 -> 0x8000
   assign tag_en = i_fp_gpio_in[radio_pkg::FP_TAG_EN_BIT];
   assign hit    = tag_en && (i_mag >= thresh);

   // hold counter saturates at TAG_HOLD
   assign cnt_next = (hold_cnt == CNT_W'(TAG_HOLD)) ? hold_cnt : hold_cnt + 1'b1;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         hold_cnt   <= '0;
         o_rx_valid <= 1'b0;
      end else if (!hit) begin
         hold_cnt   <= '0;   // any weak sample or enable low restarts the run
         o_rx_valid <= 1'b0;
      end else begin
         hold_cnt   <= cnt_next;
         o_rx_valid <= (cnt_next == CNT_W'(TAG_HOLD));
      end
   end

   // overlay copy, one sample old
   always_ff @(posedge radio_clk) begin
      o_baseband <= i_sample;
   end

   // --------------------
   // front-panel drive
   always_comb begin
      o_fp_gpio_out = '0;
      o_fp_gpio_ddr = '0;   // everything else stays an input
      o_fp_gpio_out[radio_pkg::FP_TAG_LED_BIT] = o_rx_valid;
      o_fp_gpio_ddr[radio_pkg::FP_TAG_LED_BIT] = 1'b1;
   end

endmodule

`default_nettype wire

//--- source/fe_control.sv
/* front-end control for one daughterboard
   per-channel mode registers and registered iq conditioning */
`timescale 1ns/1ps
`default_nettype none

module fe_control (
   input  wire logic                                radio_clk,
   input  wire logic                                i_rst_n,
   input  wire radio_pkg::settings_bus_t            i_set,
   input  wire logic [radio_pkg::SAMPLE_W-1:0]      i_rx,
   input  wire logic [radio_pkg::SAMPLE_W-1:0]      i_tx,
   output logic [1:0][radio_pkg::SAMPLE_W-1:0]      o_rx,
   output logic [radio_pkg::SAMPLE_W-1:0]           o_tx
);

   localparam int NUM_RX = 2;

   radio_pkg::fe_mode_e rx_mode [NUM_RX];
   radio_pkg::fe_mode_e tx_mode;

   // settings address of receive channel c
   function automatic logic [radio_pkg::SR_ADDR_W-1:0] rx_addr(input int c);
      rx_addr = radio_pkg::SR_RX_FE_BASE +
                radio_pkg::SR_ADDR_W'(c * radio_pkg::SR_FE_CHAN_OFFSET);
   endfunction

   // mode rule on one iq sample
   function automatic logic [radio_pkg::SAMPLE_W-1:0] apply_mode(
      input radio_pkg::fe_mode_e              mode,
      input logic [radio_pkg::SAMPLE_W-1:0]   s
   );
      logic [radio_pkg::IQ_W-1:0] i_part;
      logic [radio_pkg::IQ_W-1:0] q_part;
      logic [radio_pkg::IQ_W-1:0] q_neg;
      i_part = s[radio_pkg::SAMPLE_W-1 -: radio_pkg::IQ_W];
      q_part = s[radio_pkg::IQ_W-1:0];
      q_neg  = ~q_part + 1'b1;   // two's complement, wraps at -32768
      case (mode)
         radio_pkg::FE_SWAP_IQ:  apply_mode = {q_part, i_part};
         radio_pkg::FE_INVERT_Q: apply_mode = {i_part, q_neg};
         radio_pkg::FE_MUTE:     apply_mode = '0;
         default:                apply_mode = s;
      endcase
   endfunction

   // --------------------
   // mode registers
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         for (int c = 0; c < NUM_RX; c++) begin
            rx_mode[c] <= radio_pkg::FE_PASS;
         end
         tx_mode <= radio_pkg::FE_PASS;
      end else if (i_set.stb) begin
         for (int c = 0; c < NUM_RX; c++) begin
            if (i_set.addr == rx_addr(c)) begin
               rx_mode[c] <= radio_pkg::fe_mode_e'(i_set.data[1:0]);
            end
         end
         // transmit exists on channel 0 only
         if (i_set.addr == radio_pkg::SR_TX_FE_BASE) begin
            tx_mode <= radio_pkg::fe_mode_e'(i_set.data[1:0]);
         end
      end
   end

   // --------------------
   // sample path, one register stage
   always_ff @(posedge radio_clk) begin
      for (int c = 0; c < NUM_RX; c++) begin
         o_rx[c] <= apply_mode(rx_mode[c], i_rx);   // same radio on both channels
      end
      o_tx <= apply_mode(tx_mode, i_tx);
   end

endmodule

`default_nettype wire

//--- source/db_control.sv
/* daughterboard control
   gpio, direction, led and misc output registers plus readback mux */
`timescale 1ns/1ps
`default_nettype none

module db_control (
   input  wire logic                            radio_clk,
   input  wire logic                            i_rst_n,
   input  wire radio_pkg::settings_bus_t        i_set,
   input  wire radio_pkg::readback_req_t        i_rb,
   input  wire logic [radio_pkg::GPIO_W-1:0]    i_db_gpio_in,
   input  wire logic [radio_pkg::GPIO_W-1:0]    i_fp_gpio_in,
   input  wire logic [radio_pkg::MISC_W-1:0]    i_misc_in,
   output logic [radio_pkg::GPIO_W-1:0]         o_db_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0]         o_db_gpio_ddr,
   output logic [radio_pkg::LED_W-1:0]          o_leds,
   output logic [radio_pkg::MISC_W-1:0]         o_misc_out,
   output logic                                 o_rb_valid,
   output logic [radio_pkg::RB_DATA_W-1:0]      o_rb_data
);

   logic [radio_pkg::MISC_W-1:0]    misc_in_q;
   logic [radio_pkg::SR_ADDR_W-1:0] rb_ofs;
   logic                            rb_hit;
   radio_pkg::rb_sel_e              rb_sel;
   logic [radio_pkg::RB_DATA_W-1:0] rb_word;

   // --------------------
   // output registers
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_leds        <= '0;
         o_misc_out    <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            radio_pkg::SR_DB_BASE + radio_pkg::DB_GPIO_OUT_OFS:
               o_db_gpio_out <= i_set.data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_DB_BASE + radio_pkg::DB_GPIO_DDR_OFS:
               o_db_gpio_ddr <= i_set.data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_DB_BASE + radio_pkg::DB_LEDS_OFS:
               o_leds        <= i_set.data[radio_pkg::LED_W-1:0];
            radio_pkg::SR_DB_BASE + radio_pkg::DB_MISC_OUT_OFS:
               o_misc_out    <= i_set.data[radio_pkg::MISC_W-1:0];
            default: ;   // other blocks on this bus
         endcase
      end
   end

   // misc pins land here one cycle after the pin
   always_ff @(posedge radio_clk) begin
      misc_in_q <= i_misc_in;
   end

   // --------------------
   // readback
   assign rb_ofs = i_rb.addr - radio_pkg::RB_DB_BASE;
   assign rb_hit = (rb_ofs < radio_pkg::SR_ADDR_W'(4));
   assign rb_sel = radio_pkg::rb_sel_e'(rb_ofs[1:0]);

   always_comb begin
      case (rb_sel)
         radio_pkg::RB_MISC_IN:    rb_word = radio_pkg::RB_DATA_W'(misc_in_q);
         radio_pkg::RB_DB_GPIO_IN: rb_word = radio_pkg::RB_DATA_W'(i_db_gpio_in);
         radio_pkg::RB_FP_GPIO_IN: rb_word = radio_pkg::RB_DATA_W'(i_fp_gpio_in);
         radio_pkg::RB_OUT_ECHO:   rb_word = {o_misc_out, o_db_gpio_out};
         default:                  rb_word = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_valid <= 1'b0;
      end else begin
         o_rb_valid <= i_rb.stb;   // single-cycle answer
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rb.stb) begin
         o_rb_data <= rb_hit ? rb_word : '0;   // unknown address reads 0
      end
   end

endmodule

`default_nettype wire

//--- source/radio_pkg.sv
/* radio core shared definitions
   widths, settings and readback maps, bus structs and mode enums */
`default_nettype none

package radio_pkg;

   // --------------------
   // widths
   localparam int SAMPLE_W   = 32;   // I in [31:16], Q in [15:0]
   localparam int IQ_W       = 16;
   localparam int SR_ADDR_W  = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_DATA_W  = 64;
   localparam int GPIO_W     = 32;
   localparam int FP_GPIO_W  = 12;   // front-panel pins in use
   localparam int LED_W      = 3;
   localparam int MISC_W     = 32;

   // --------------------
   // settings register map
   localparam logic [SR_ADDR_W-1:0] SR_DB_BASE        = 8'd160;
   localparam logic [SR_ADDR_W-1:0] DB_GPIO_OUT_OFS   = 8'd0;
   localparam logic [SR_ADDR_W-1:0] DB_GPIO_DDR_OFS   = 8'd1;
   localparam logic [SR_ADDR_W-1:0] DB_LEDS_OFS       = 8'd2;
   localparam logic [SR_ADDR_W-1:0] DB_MISC_OUT_OFS   = 8'd3;
   localparam logic [SR_ADDR_W-1:0] SR_TAG_THRESH     = 8'd176;  // board 1 only
   localparam logic [SR_ADDR_W-1:0] SR_TX_FE_BASE     = 8'd208;
   localparam logic [SR_ADDR_W-1:0] SR_RX_FE_BASE     = 8'd224;
   localparam int                   SR_FE_CHAN_OFFSET = 16;

   // readback map, offsets given by rb_sel_e
   localparam logic [SR_ADDR_W-1:0] RB_DB_BASE = 8'd16;

   // front-panel bits used by the tag detector
   localparam int FP_TAG_EN_BIT  = 1;
   localparam int FP_TAG_LED_BIT = 0;

   // --------------------
   // bus types
   typedef struct packed {
      logic                  stb;
      logic                  db_sel;
      logic [SR_ADDR_W-1:0]  addr;
      logic [SET_DATA_W-1:0] data;
   } settings_bus_t;

   typedef struct packed {
      logic                 stb;
      logic                 db_sel;
      logic [SR_ADDR_W-1:0] addr;
   } readback_req_t;

   typedef enum logic [1:0] {
      FE_PASS     = 2'd0,
      FE_SWAP_IQ  = 2'd1,
      FE_INVERT_Q = 2'd2,
      FE_MUTE     = 2'd3
   } fe_mode_e;

   typedef enum logic [1:0] {
      RB_MISC_IN    = 2'd0,
      RB_DB_GPIO_IN = 2'd1,
      RB_FP_GPIO_IN = 2'd2,
      RB_OUT_ECHO   = 2'd3   // {misc out, gpio out}
   } rb_sel_e;

endpackage

`default_nettype wire
